/* Bender.yml */
package:
  name: vector_adder

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/vector_adder_pkg.sv
      - logic/vector_operand_capture.sv
      - logic/vector_sequencer.sv
      - logic/scalar_adder.sv
      - logic/vector_result_stage.sv
      - logic/vector_adder.sv
  - target: test
    include_dirs:
      - logic
    files:
      - sim/tb_vector_adder.sv

/* logic/scalar_adder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "vector_adder_config.svh"

module scalar_adder
  import vector_adder_pkg::*;
(
  input  logic          CLK,
  input  logic          RST,
  input  operand_pair_t pair,
  input  logic          pair_valid,
  output adder_result_t result,
  output logic          result_valid
);

  // Stage 1 operands
  logic [`VA_DATA_WIDTH-1:0] s1_a;
  // B, inverted for subtraction
  logic [`VA_DATA_WIDTH-1:0] s1_b;
  // Carry in completing the two's complement of B
  logic                      s1_carry;
  logic                      s1_valid;

  //////////////////////////////////////////////////////////////////////
  // Valid pipeline
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid     <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      s1_valid     <= pair_valid;
      result_valid <= s1_valid;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Data pipeline
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    // Stage 1
    if (pair_valid) begin
      s1_a     <= pair.a;
      s1_b     <= pair.subtract ? ~pair.b : pair.b;
      s1_carry <= pair.subtract;
    end
    // Stage 2 with the sum wrapping at the data width
    if (s1_valid) begin
      result.sum <= s1_a + s1_b + {{(`VA_DATA_WIDTH-1){1'b0}}, s1_carry};
    end
  end

  // Fixed two cycle latency without stalls
  a_latency : assert property (@(posedge CLK) disable iff (RST)
    pair_valid |-> ##2 result_valid)
    else $error("result_valid missing two cycles after pair_valid");

  a_no_spurious : assert property (@(posedge CLK) disable iff (RST)
    result_valid |-> $past(pair_valid, 2))
    else $error("result_valid without matching pair_valid");

endmodule

`default_nettype wire

/* logic/vector_adder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "vector_adder_config.svh"

module vector_adder
  import vector_adder_pkg::*;
(
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      START,
  input  logic                      OPERATION,
  input  logic                      DATA_A_IN_ENABLE,
  input  logic [`VA_DATA_WIDTH-1:0] DATA_A_IN,
  input  logic                      DATA_B_IN_ENABLE,
  input  logic [`VA_DATA_WIDTH-1:0] DATA_B_IN,
  input  logic [`VA_LEN_WIDTH-1:0]  SIZE_IN,
  output logic [`VA_DATA_WIDTH-1:0] DATA_OUT,
  output logic                      DATA_OUT_ENABLE,
  output logic                      READY
);

  // Control between blocks
  logic armed;
  logic pair_valid;
  logic result_valid;
  logic last_result;

  // Payload between blocks
  operand_pair_t pair;
  adder_result_t result;

  //////////////////////////////////////////////////////////////////////
  // Input side
  //////////////////////////////////////////////////////////////////////

  vector_operand_capture u_capture (
    .CLK              (CLK),
    .RST              (RST),
    .armed            (armed),
    .DATA_A_IN_ENABLE (DATA_A_IN_ENABLE),
    .DATA_B_IN_ENABLE (DATA_B_IN_ENABLE),
    .DATA_A_IN        (DATA_A_IN),
    .DATA_B_IN        (DATA_B_IN),
    .OPERATION        (OPERATION),
    .pair             (pair),
    .pair_valid       (pair_valid)
  );

  //////////////////////////////////////////////////////////////////////
  // Processing
  //////////////////////////////////////////////////////////////////////

  vector_sequencer u_sequencer (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .SIZE_IN      (SIZE_IN),
    .pair_valid   (pair_valid),
    .result_valid (result_valid),
    .armed        (armed),
    .last_result  (last_result)
  );

  // Two stage add/subtract
  scalar_adder u_adder (
    .CLK          (CLK),
    .RST          (RST),
    .pair         (pair),
    .pair_valid   (pair_valid),
    .result       (result),
    .result_valid (result_valid)
  );

  //////////////////////////////////////////////////////////////////////
  // Output side
  //////////////////////////////////////////////////////////////////////

  vector_result_stage u_result (
    .CLK             (CLK),
    .RST             (RST),
    .result          (result),
    .result_valid    (result_valid),
    .last_result     (last_result),
    .DATA_OUT        (DATA_OUT),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .READY           (READY)
  );

endmodule

`default_nettype wire

/* logic/vector_adder_config.svh */
`ifndef VECTOR_ADDER_CONFIG_SVH
`define VECTOR_ADDER_CONFIG_SVH

// Width of one vector element and of DATA_OUT
`define VA_DATA_WIDTH 32

// Width of SIZE_IN and the element counters
`define VA_LEN_WIDTH 16

`endif

/* logic/vector_adder_pkg.sv */
`default_nettype none

`include "vector_adder_config.svh"

package vector_adder_pkg;

  // One element pair on its way into the adder
  typedef struct packed {
    logic [`VA_DATA_WIDTH-1:0] a;
    logic [`VA_DATA_WIDTH-1:0] b;
    // Set for A minus B
    logic                      subtract;
  } operand_pair_t;

  // One finished element
  typedef struct packed {
    logic [`VA_DATA_WIDTH-1:0] sum;
  } adder_result_t;

  // Sequencer states
  typedef enum logic {
    SEQ_IDLE = 1'b0,
    SEQ_RUN  = 1'b1
  } seq_state_t;

endpackage

`default_nettype wire

/* logic/vector_operand_capture.sv */
`timescale 1ns/1ns
`default_nettype none

`include "vector_adder_config.svh"

module vector_operand_capture
  import vector_adder_pkg::*;
(
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      armed,
  input  logic                      DATA_A_IN_ENABLE,
  input  logic                      DATA_B_IN_ENABLE,
  input  logic [`VA_DATA_WIDTH-1:0] DATA_A_IN,
  input  logic [`VA_DATA_WIDTH-1:0] DATA_B_IN,
  input  logic                      OPERATION,
  output operand_pair_t             pair,
  output logic                      pair_valid
);

  // Held operand values
  logic [`VA_DATA_WIDTH-1:0] a_q;
  logic [`VA_DATA_WIDTH-1:0] b_q;

  // Held flags, one per operand
  logic held_a;
  logic held_b;

  // Operand present from either a strobe or an earlier capture
  logic have_a;
  logic have_b;
  logic release_pair;

  assign have_a       = held_a | DATA_A_IN_ENABLE;
  assign have_b       = held_b | DATA_B_IN_ENABLE;
  // Strobes only count while a vector is armed
  assign release_pair = armed & have_a & have_b;

  //////////////////////////////////////////////////////////////////////
  // Operand holding registers
  //////////////////////////////////////////////////////////////////////

  // Any armed strobe lands here while the pair reads the previous value
  always_ff @(posedge CLK) begin
    if (armed && DATA_A_IN_ENABLE) begin
      a_q <= DATA_A_IN;
    end
    if (armed && DATA_B_IN_ENABLE) begin
      b_q <= DATA_B_IN;
    end
  end

  // Held flags and release strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      held_a     <= 1'b0;
      held_b     <= 1'b0;
      pair_valid <= 1'b0;
    end else begin
      pair_valid <= release_pair;
      if (!armed) begin
        // Nothing carries over between vectors
        held_a <= 1'b0;
        held_b <= 1'b0;
      end else if (release_pair) begin
        // A strobe on an already held operand waits for the next pair
        held_a <= held_a & DATA_A_IN_ENABLE;
        held_b <= held_b & DATA_B_IN_ENABLE;
      end else begin
        held_a <= have_a;
        held_b <= have_b;
      end
    end
  end

  // Released pair with the OPERATION level of that edge
  always_ff @(posedge CLK) begin
    if (release_pair) begin
      pair.a        <= held_a ? a_q : DATA_A_IN;
      pair.b        <= held_b ? b_q : DATA_B_IN;
      pair.subtract <= OPERATION;
    end
  end

  // Held A may only be strobed again on a release edge
  a_no_overwrite_a : assert property (@(posedge CLK) disable iff (RST)
    (armed && held_a && DATA_A_IN_ENABLE) |-> release_pair)
    else $error("operand A overwritten before release");

  a_no_overwrite_b : assert property (@(posedge CLK) disable iff (RST)
    (armed && held_b && DATA_B_IN_ENABLE) |-> release_pair)
    else $error("operand B overwritten before release");

endmodule

`default_nettype wire

/* logic/vector_result_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "vector_adder_config.svh"

module vector_result_stage
  import vector_adder_pkg::*;
(
  input  logic                      CLK,
  input  logic                      RST,
  input  adder_result_t             result,
  input  logic                      result_valid,
  input  logic                      last_result,
  output logic [`VA_DATA_WIDTH-1:0] DATA_OUT,
  output logic                      DATA_OUT_ENABLE,
  output logic                      READY
);

  //////////////////////////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      DATA_OUT        <= '0;
      DATA_OUT_ENABLE <= 1'b0;
      READY           <= 1'b0;
    end else begin
      // One cycle strobes
      DATA_OUT_ENABLE <= result_valid;
      READY           <= last_result;
      // Sum held between elements
      if (result_valid) begin
        DATA_OUT <= result.sum;
      end
    end
  end

  // READY only together with the final DATA_OUT_ENABLE
  a_ready_with_data : assert property (@(posedge CLK) disable iff (RST)
    READY |-> DATA_OUT_ENABLE)
    else $error("READY without DATA_OUT_ENABLE");

endmodule

`default_nettype wire

/* logic/vector_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "vector_adder_config.svh"

module vector_sequencer
  import vector_adder_pkg::*;
(
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     START,
  input  logic [`VA_LEN_WIDTH-1:0] SIZE_IN,
  input  logic                     pair_valid,
  input  logic                     result_valid,
  output logic                     armed,
  output logic                     last_result
);

  localparam logic [`VA_LEN_WIDTH-1:0] LEN_ONE = `VA_LEN_WIDTH'(1);

  seq_state_t state;

  // Latched vector length
  logic [`VA_LEN_WIDTH-1:0] length_q;

  // Pairs sent into the adder
  logic [`VA_LEN_WIDTH-1:0] issued_q;
  // Results seen from the adder
  logic [`VA_LEN_WIDTH-1:0] completed_q;

  // Issued count including a release still on pair_valid
  logic [`VA_LEN_WIDTH-1:0] issued_next;
  logic                     running;

  assign running     = (state == SEQ_RUN);
  assign issued_next = issued_q + (pair_valid ? LEN_ONE : '0);

  // Capture closes as soon as the final pair is released
  assign armed       = running && (issued_next < length_q);

  // Final element leaving the adder
  assign last_result = running && result_valid && (completed_q == length_q - LEN_ONE);

  //////////////////////////////////////////////////////////////////////
  // IDLE / RUN state machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state       <= SEQ_IDLE;
      length_q    <= '0;
      issued_q    <= '0;
      completed_q <= '0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          // Zero length START is dropped
          if (START && (SIZE_IN != '0)) begin
            length_q    <= SIZE_IN;
            issued_q    <= '0;
            completed_q <= '0;
            state       <= SEQ_RUN;
          end
        end
        SEQ_RUN: begin
          // START ignored here
          issued_q <= issued_next;
          if (result_valid) begin
            completed_q <= completed_q + LEN_ONE;
          end
          if (last_result) begin
            state <= SEQ_IDLE;
          end
        end
        default: begin
          state <= SEQ_IDLE;
        end
      endcase
    end
  end

  // A pair is only released on an edge where capture was armed
  a_pair_when_armed : assert property (@(posedge CLK) disable iff (RST)
    pair_valid |-> $past(armed))
    else $error("pair released while capture not armed");

  // Results only arrive for an active vector
  a_result_in_run : assert property (@(posedge CLK) disable iff (RST)
    result_valid |-> running)
    else $error("result seen while sequencer idle");

endmodule

`default_nettype wire

/* sim/tb_vector_adder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "vector_adder_config.svh"

module tb_vector_adder;

  localparam int W = `VA_DATA_WIDTH;

  // One pending result as the monitor expects it
  typedef struct packed {
    logic [W-1:0] data;
    logic [31:0]  out_edge;
    logic         last;
  } expect_t;

  logic                     CLK;
  logic                     RST;
  logic                     START;
  logic                     OPERATION;
  logic                     DATA_A_IN_ENABLE;
  logic [W-1:0]             DATA_A_IN;
  logic                     DATA_B_IN_ENABLE;
  logic [W-1:0]             DATA_B_IN;
  logic [`VA_LEN_WIDTH-1:0] SIZE_IN;
  logic [W-1:0]             DATA_OUT;
  logic                     DATA_OUT_ENABLE;
  logic                     READY;

  expect_t     exp_q[$];
  logic [31:0] edge_cnt = '0;
  int          value_errors = 0;
  int          timing_errors = 0;
  int          other_errors = 0;
  int          out_count = 0;
  int          ready_count = 0;

  // Reference model of the capture side
  logic [W-1:0] mdl_a;
  logic [W-1:0] mdl_b;
  logic         mdl_have_a;
  logic         mdl_have_b;
  int           mdl_left = 0;

  vector_adder UUT (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .OPERATION        (OPERATION),
    .DATA_A_IN_ENABLE (DATA_A_IN_ENABLE),
    .DATA_A_IN        (DATA_A_IN),
    .DATA_B_IN_ENABLE (DATA_B_IN_ENABLE),
    .DATA_B_IN        (DATA_B_IN),
    .SIZE_IN          (SIZE_IN),
    .DATA_OUT         (DATA_OUT),
    .DATA_OUT_ENABLE  (DATA_OUT_ENABLE),
    .READY            (READY)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // Rising edges since time zero
  always @(posedge CLK) begin
    edge_cnt <= edge_cnt + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // Output monitor on the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge CLK) begin
    expect_t e;
    if (!RST) begin
      if (READY) begin
        ready_count++;
      end
      if (READY && !DATA_OUT_ENABLE) begin
        value_errors++;
        $display("[ERROR] %0t READY expected %b got %b", $time, 1'b0, READY);
      end
      if (DATA_OUT_ENABLE) begin
        out_count++;
        if (exp_q.size() == 0) begin
          other_errors++;
          $display("[ERROR] %0t DATA_OUT_ENABLE expected %b got %b",
                   $time, 1'b0, DATA_OUT_ENABLE);
        end else begin
          e = exp_q.pop_front();
          if (DATA_OUT !== e.data) begin
            value_errors++;
            $display("[ERROR] %0t DATA_OUT expected %h got %h", $time, e.data, DATA_OUT);
          end
          if (edge_cnt !== e.out_edge) begin
            timing_errors++;
            $display("[ERROR] %0t DATA_OUT_ENABLE edge expected %0d got %0d",
                     $time, e.out_edge, edge_cnt);
          end
          if (READY !== e.last) begin
            value_errors++;
            $display("[ERROR] %0t READY expected %b got %b", $time, e.last, READY);
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // One cycle of element strobes with the model updated alongside
  task automatic strobe(input logic en_a, input logic [W-1:0] a,
                        input logic en_b, input logic [W-1:0] b, input logic op);
    expect_t e;
    @(posedge CLK);
    DATA_A_IN_ENABLE <= en_a;
    DATA_A_IN        <= a;
    DATA_B_IN_ENABLE <= en_b;
    DATA_B_IN        <= b;
    OPERATION        <= op;
    // Strobes only count inside a vector
    if (mdl_left > 0) begin
      if (en_a) begin
        mdl_a      = a;
        mdl_have_a = 1'b1;
      end
      if (en_b) begin
        mdl_b      = b;
        mdl_have_b = 1'b1;
      end
      if (mdl_have_a && mdl_have_b) begin
        mdl_left--;
        // Modular add or A minus B
        e.data     = op ? (mdl_a - mdl_b) : (mdl_a + mdl_b);
        // Output three edges after the edge that samples these strobes
        e.out_edge = edge_cnt + 5;
        e.last     = (mdl_left == 0);
        exp_q.push_back(e);
        mdl_have_a = 1'b0;
        mdl_have_b = 1'b0;
      end
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge CLK);
      DATA_A_IN_ENABLE <= 1'b0;
      DATA_B_IN_ENABLE <= 1'b0;
    end
  endtask

  task automatic start_vector(input int len);
    @(posedge CLK);
    START            <= 1'b1;
    SIZE_IN          <= `VA_LEN_WIDTH'(len);
    DATA_A_IN_ENABLE <= 1'b0;
    DATA_B_IN_ENABLE <= 1'b0;
    // Busy or zero length START has no effect
    if (mdl_left == 0 && len != 0) begin
      mdl_left   = len;
      mdl_have_a = 1'b0;
      mdl_have_b = 1'b0;
    end
    @(posedge CLK);
    START <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 100) begin
      @(posedge CLK);
      waited++;
    end
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("Timed out at %0t with %0d results still pending", $time, exp_q.size());
      exp_q.delete();
    end
    // Quiet stretch to catch stray outputs
    idle_cycles(6);
  endtask

  task automatic compare_counts(input int outs0, input int rdy0,
                                input int exp_outs, input int exp_ready);
    if (out_count - outs0 != exp_outs) begin
      value_errors++;
      $display("[ERROR] %0t DATA_OUT_ENABLE pulses expected %0d got %0d",
               $time, exp_outs, out_count - outs0);
    end
    if (ready_count - rdy0 != exp_ready) begin
      value_errors++;
      $display("[ERROR] %0t READY pulses expected %0d got %0d",
               $time, exp_ready, ready_count - rdy0);
    end
  endtask

  task automatic expect_quiet_outputs();
    if (DATA_OUT_ENABLE !== 1'b0) begin
      value_errors++;
      $display("[ERROR] %0t DATA_OUT_ENABLE expected 0 got %b", $time, DATA_OUT_ENABLE);
    end
    if (READY !== 1'b0) begin
      value_errors++;
      $display("[ERROR] %0t READY expected 0 got %b", $time, READY);
    end
    if (DATA_OUT !== '0) begin
      value_errors++;
      $display("[ERROR] %0t DATA_OUT expected 0 got %h", $time, DATA_OUT);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  // Reset released on the fifth rising edge
  task automatic reset_state();
    repeat (4) begin
      @(negedge CLK);
      expect_quiet_outputs();
    end
    @(posedge CLK);
    RST <= 1'b0;
    repeat (3) begin
      @(negedge CLK);
      expect_quiet_outputs();
    end
  endtask

  // Four additions with both strobes together
  task automatic add_same_cycle();
    int outs0;
    int rdy0;
    outs0 = out_count;
    rdy0  = ready_count;
    start_vector(4);
    strobe(1'b1, 32'h0000_0001, 1'b1, 32'h0000_0002, 1'b0);
    idle_cycles(1);
    strobe(1'b1, 32'h1234_5678, 1'b1, 32'h1111_1111, 1'b0);
    idle_cycles(2);
    strobe(1'b1, 32'h7fff_ffff, 1'b1, 32'h0000_0001, 1'b0);
    idle_cycles(1);
    strobe(1'b1, 32'hffff_ffff, 1'b1, 32'h0000_0003, 1'b0);
    idle_cycles(1);
    wait_drain();
    compare_counts(outs0, rdy0, 4, 1);
  endtask

  // Subtraction with wrap for A first and for B first
  task automatic subtract_split();
    int outs0;
    int rdy0;
    outs0 = out_count;
    rdy0  = ready_count;
    start_vector(3);
    strobe(1'b1, 32'h0000_0005, 1'b0, '0, 1'b1);
    idle_cycles(2);
    strobe(1'b0, '0, 1'b1, 32'h0000_0007, 1'b1);
    idle_cycles(1);
    strobe(1'b0, '0, 1'b1, 32'h0000_0001, 1'b1);
    idle_cycles(1);
    strobe(1'b1, 32'h0000_0000, 1'b0, '0, 1'b1);
    idle_cycles(1);
    // OPERATION of the later strobe decides
    strobe(1'b1, 32'h8000_0000, 1'b0, '0, 1'b0);
    strobe(1'b0, '0, 1'b1, 32'h0000_0001, 1'b1);
    idle_cycles(1);
    wait_drain();
    compare_counts(outs0, rdy0, 3, 1);
  endtask

  // One pair per cycle with two in flight
  task automatic back_to_back();
    int           outs0;
    int           rdy0;
    logic [W-1:0] a_val;
    logic [W-1:0] b_val;
    outs0 = out_count;
    rdy0  = ready_count;
    start_vector(6);
    for (int i = 0; i < 6; i++) begin
      a_val = 32'hffff_fff0 + i * 3;
      b_val = i * 7 + 2;
      strobe(1'b1, a_val, 1'b1, b_val, i[0]);
    end
    idle_cycles(1);
    wait_drain();
    compare_counts(outs0, rdy0, 6, 1);
  endtask

  task automatic ignored_inputs();
    int outs0;
    int rdy0;
    outs0 = out_count;
    rdy0  = ready_count;
    // Strobes with no vector
    strobe(1'b1, 32'hdead_beef, 1'b1, 32'h0000_0001, 1'b0);
    strobe(1'b1, 32'h0000_0010, 1'b0, '0, 1'b0);
    idle_cycles(1);
    strobe(1'b0, '0, 1'b1, 32'h0000_0020, 1'b0);
    idle_cycles(4);
    // Zero length START
    start_vector(0);
    strobe(1'b1, 32'h0000_0003, 1'b1, 32'h0000_0004, 1'b0);
    idle_cycles(6);
    compare_counts(outs0, rdy0, 0, 0);
    // Second START mid vector
    start_vector(3);
    strobe(1'b1, 32'h0000_000a, 1'b1, 32'h0000_0014, 1'b0);
    idle_cycles(1);
    start_vector(5);
    strobe(1'b1, 32'h0000_001e, 1'b1, 32'h0000_0004, 1'b1);
    strobe(1'b1, 32'h0000_0100, 1'b1, 32'h0000_0200, 1'b0);
    idle_cycles(1);
    wait_drain();
    compare_counts(outs0, rdy0, 3, 1);
  endtask

  task automatic random_vectors(input int vectors);
    int           len;
    int           order;
    int           outs0;
    int           rdy0;
    logic [W-1:0] a_val;
    logic [W-1:0] b_val;
    logic         op;
    for (int v = 0; v < vectors; v++) begin
      outs0 = out_count;
      rdy0  = ready_count;
      len   = 1 + ($urandom % 8);
      start_vector(len);
      for (int i = 0; i < len; i++) begin
        a_val = $urandom;
        b_val = $urandom;
        op    = $urandom % 2;
        order = $urandom % 3;
        case (order)
          0: strobe(1'b1, a_val, 1'b1, b_val, op);
          1: begin
            strobe(1'b1, a_val, 1'b0, '0, op);
            idle_cycles($urandom % 3);
            strobe(1'b0, '0, 1'b1, b_val, op);
          end
          default: begin
            strobe(1'b0, '0, 1'b1, b_val, op);
            idle_cycles($urandom % 3);
            strobe(1'b1, a_val, 1'b0, '0, op);
          end
        endcase
        idle_cycles($urandom % 3);
      end
      idle_cycles(1);
      wait_drain();
      compare_counts(outs0, rdy0, len, 1);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h9c2c_cf7c));
    RST              = 1'b1;
    START            = 1'b0;
    OPERATION        = 1'b0;
    DATA_A_IN_ENABLE = 1'b0;
    DATA_A_IN        = '0;
    DATA_B_IN_ENABLE = 1'b0;
    DATA_B_IN        = '0;
    SIZE_IN          = '0;
    reset_state();
    add_same_cycle();
    subtract_split();
    back_to_back();
    ignored_inputs();
    random_vectors(6);
    $display("Errors: value %0d, timing %0d, other %0d",
             value_errors, timing_errors, other_errors);
    if (value_errors + timing_errors + other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+logic
logic/vector_adder_pkg.sv
logic/vector_operand_capture.sv
logic/vector_sequencer.sv
logic/scalar_adder.sv
logic/vector_result_stage.sv
logic/vector_adder.sv
sim/tb_vector_adder.sv
